//--- Bender.yml
package:
  name: itm_trace_port

sources:
  - src/dbg_noc_pkg.sv
  - src/flit_fifo.sv
  - src/dbg_conf_if.sv
  - src/itm_dbgnoc_if.sv
  - src/itm_trace_port.sv
  - target: test
    files:
      - test/tb_itm_trace_port.sv

//--- sources.f
src/dbg_noc_pkg.sv
src/flit_fifo.sv
src/dbg_conf_if.sv
src/itm_dbgnoc_if.sv
src/itm_trace_port.sv
test/tb_itm_trace_port.sv

//--- src/dbg_conf_if.sv
// Configuration register interface
module dbg_conf_if #(
   parameter logic [7:0] CORE_ID = 8'h00
) (
   input  logic                   clk,
   input  logic                   rst,
   input  dbg_noc_pkg::dbg_flit_t in_flit,
   input  logic                   in_valid,
   output logic                   in_ready,
   output dbg_noc_pkg::dbg_flit_t out_flit,
   output logic                   out_valid,
   input  logic                   out_ready,
   output logic                   conf_rts,
   input  logic                   conf_cts,
   output dbg_noc_pkg::itm_conf_t conf
);

   localparam int IDX_W = $clog2(dbg_noc_pkg::CONF_MEM_SIZE);

   // receive side
   typedef enum logic [1:0] {RX_IDLE, RX_ADDR, RX_DATA, RX_DISCARD} rx_state_e;
   // response side
   typedef enum logic [1:0] {TX_IDLE, TX_HDR, TX_ADDR, TX_DATA} tx_state_e;

   rx_state_e                rx_state;
   tx_state_e                tx_state;
   dbg_noc_pkg::pkt_header_t hdr_in;   // incoming word seen as header
   dbg_noc_pkg::pkt_header_t resp_hdr;
   dbg_noc_pkg::pkt_class_e  cls_q;    // class of packet in flight
   logic [7:0]               src_q;    // requester id
   logic [15:0]              addr_q;   // register address
   logic [15:0]              rd_data;
   logic [15:0]              conf_mem [dbg_noc_pkg::CONF_MEM_SIZE];
   logic                     in_acc;
   logic                     out_acc;

   assign hdr_in   = dbg_noc_pkg::pkt_header_t'(in_flit.data);
   assign in_ready = (tx_state == TX_IDLE); // reads hold input off until answered
   assign in_acc   = in_valid && in_ready;
   assign conf_rts = (tx_state != TX_IDLE);
   assign out_valid = conf_rts && conf_cts; // only drive the link once granted
   assign out_acc  = out_valid && out_ready;

   // register map view for reads
   always_comb begin
      conf_mem[0] = {dbg_noc_pkg::MODULE_TYPE_ITM, dbg_noc_pkg::MODULE_VERSION_ITM};
      conf_mem[1] = {8'h00, CORE_ID};
      conf_mem[2] = conf.pc_lower[31:16];
      conf_mem[3] = conf.pc_lower[15:0];
      conf_mem[4] = conf.pc_upper[31:16];
      conf_mem[5] = conf.pc_upper[15:0];
   end

   assign rd_data = (addr_q < 16'(dbg_noc_pkg::CONF_MEM_SIZE)) ?
                    conf_mem[addr_q[IDX_W-1:0]] : 16'h0000; // unmapped reads give 0

   // answer goes back to whoever asked
   assign resp_hdr = '{dest: src_q[4:0], pclass: dbg_noc_pkg::PKT_CLASS_CONF_RESP,
                       src: CORE_ID};

   always_comb begin
      out_flit = '{ftype: dbg_noc_pkg::FLIT_PAYLOAD, data: 16'h0000};
      case (tx_state)
         TX_HDR:  out_flit = '{ftype: dbg_noc_pkg::FLIT_HEADER, data: resp_hdr};
         TX_ADDR: out_flit = '{ftype: dbg_noc_pkg::FLIT_PAYLOAD, data: addr_q};
         TX_DATA: out_flit = '{ftype: dbg_noc_pkg::FLIT_LAST, data: rd_data};
         default: ;
      endcase
   end

   // packet fields
   always_ff @(posedge clk) begin
      if (in_acc && rx_state == RX_IDLE) begin
         cls_q <= hdr_in.pclass;
         src_q <= hdr_in.src;
      end
      if (in_acc && rx_state == RX_ADDR) addr_q <= in_flit.data;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rx_state <= RX_IDLE;
         tx_state <= TX_IDLE;
         conf.pc_lower <= 32'h0000_0000;
         conf.pc_upper <= 32'hffff_ffff; // upper bound wide open
      end else begin
         case (rx_state)
            RX_IDLE: if (in_acc) begin
               if (hdr_in.pclass == dbg_noc_pkg::PKT_CLASS_CONF_WRITE ||
                   hdr_in.pclass == dbg_noc_pkg::PKT_CLASS_CONF_READ) begin
                  rx_state <= RX_ADDR;
               end else if (in_flit.ftype != dbg_noc_pkg::FLIT_LAST) begin
                  rx_state <= RX_DISCARD; // foreign packet, swallow the rest
               end
            end
            RX_ADDR: if (in_acc) begin
               if (cls_q == dbg_noc_pkg::PKT_CLASS_CONF_READ) begin
                  rx_state <= RX_IDLE;
                  tx_state <= TX_HDR; // start response
               end else if (in_flit.ftype == dbg_noc_pkg::FLIT_LAST) begin
                  rx_state <= RX_IDLE; // write without data
               end else begin
                  rx_state <= RX_DATA;
               end
            end
            RX_DATA: if (in_acc) begin
               case (addr_q)
                  16'd2: conf.pc_lower[31:16] <= in_flit.data;
                  16'd3: conf.pc_lower[15:0]  <= in_flit.data;
                  16'd4: conf.pc_upper[31:16] <= in_flit.data;
                  16'd5: conf.pc_upper[15:0]  <= in_flit.data;
                  default: ; // read-only or unmapped
               endcase
               rx_state <= (in_flit.ftype == dbg_noc_pkg::FLIT_LAST) ? RX_IDLE : RX_DISCARD;
            end
            RX_DISCARD: if (in_acc && in_flit.ftype == dbg_noc_pkg::FLIT_LAST) begin
               rx_state <= RX_IDLE;
            end
            default: rx_state <= RX_IDLE;
         endcase

         case (tx_state)
            TX_HDR:  if (out_acc) tx_state <= TX_ADDR;
            TX_ADDR: if (out_acc) tx_state <= TX_DATA;
            TX_DATA: if (out_acc) tx_state <= TX_IDLE; // rts drops with it
            default: ;
         endcase
      end
   end

endmodule

//--- src/dbg_noc_pkg.sv
// Debug network shared types
package dbg_noc_pkg;

   // flit kind
   typedef enum logic [1:0] {
      FLIT_PAYLOAD = 2'b00,
      FLIT_HEADER  = 2'b01,
      FLIT_LAST    = 2'b10
   } flit_type_e;

   // one 16-bit network flit plus its kind
   typedef struct packed {
      flit_type_e  ftype;
      logic [15:0] data;
   } dbg_flit_t; // 18 bits

   // packet class, carried in every header
   typedef enum logic [2:0] {
      PKT_CLASS_TRACE      = 3'd0,
      PKT_CLASS_CONF_WRITE = 3'd1,
      PKT_CLASS_CONF_READ  = 3'd2,
      PKT_CLASS_CONF_RESP  = 3'd3
   } pkt_class_e;

   // data word of a header flit
   typedef struct packed {
      logic [4:0]  dest;   // destination module
      pkt_class_e  pclass;
      logic [7:0]  src;    // sender id
   } pkt_header_t; // 16 bits

   // one compressed trace record from the compressor
   typedef struct packed {
      logic [31:0] timestamp;
      logic [31:0] pc;
      logic [7:0]  icount;    // instructions retired since last record
   } trace_rec_t; // 72 bits

   // writable trigger bounds
   typedef struct packed {
      logic [31:0] pc_lower;
      logic [31:0] pc_upper;
   } itm_conf_t; // 64 bits

   // external debug host sits at address 0
   localparam logic [4:0] HOST_ADDR = 5'd0;

   // module identification in register 0
   localparam logic [7:0] MODULE_TYPE_ITM    = 8'h02;
   localparam logic [7:0] MODULE_VERSION_ITM = 8'h00;

   // register map size in 16-bit words
   localparam int CONF_MEM_SIZE = 6;

   // flits per trace packet
   // header, ts msb, ts lsb, pc msb, pc lsb, count
   localparam int TRACE_PKT_LEN = 6;

endpackage

//--- src/flit_fifo.sv
// Valid/ready register FIFO
module flit_fifo #(
   parameter int WIDTH = 18,
   parameter int DEPTH = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [WIDTH-1:0] in_data,
   input  logic             in_valid,
   output logic             in_ready,
   output logic [WIDTH-1:0] out_data,
   output logic             out_valid,
   input  logic             out_ready
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH]; // storage, no reset
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;       // entries held
   logic             push;
   logic             pop;

   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr]; // head entry always shown
   // full fifo still takes a word when the head leaves this cycle
   assign in_ready  = (count != CNT_W'(DEPTH)) || out_ready;
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1; // wrap at depth
   endfunction

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= ptr_inc(wr_ptr);
         if (pop) rd_ptr <= ptr_inc(rd_ptr);
         if (push && !pop) count <= count + 1'b1;
         else if (pop && !push) count <= count - 1'b1; // simultaneous: no change
      end
   end

endmodule

//--- src/itm_dbgnoc_if.sv
// Trace packer and link arbiter
module itm_dbgnoc_if #(
   parameter logic [7:0] CORE_ID = 8'h00
) (
   input  logic                    clk,
   input  logic                    rst,
   input  dbg_noc_pkg::trace_rec_t rec,
   input  logic                    rec_valid,
   output logic                    rec_ready,
   input  logic                    trace_full,
   output dbg_noc_pkg::dbg_flit_t  net_out_flit,
   output logic                    net_out_valid,
   input  logic                    net_out_ready,
   input  dbg_noc_pkg::dbg_flit_t  conf_out_flit,
   input  logic                    conf_out_valid,
   input  logic                    conf_rts,
   output logic                    conf_cts,
   output logic                    sys_clk_disable
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_CONF,    // link lent to config responses
      ST_HEADER,
      ST_TS_MSB,
      ST_TS_LSB,
      ST_PC_MSB,
      ST_PC_LSB,
      ST_COUNT
   } state_e;

   state_e                   state;
   state_e                   state_next;
   dbg_noc_pkg::trace_rec_t  rec_buf;    // record being cut into flits
   dbg_noc_pkg::pkt_header_t trace_hdr;
   dbg_noc_pkg::dbg_flit_t   pk_flit;    // packer to output fifo
   logic                     pk_valid;
   logic                     pk_ready;
   dbg_noc_pkg::dbg_flit_t   fifo_flit;  // output fifo head
   logic                     fifo_valid;
   logic                     fifo_empty;

   assign trace_hdr = '{dest: dbg_noc_pkg::HOST_ADDR, pclass: dbg_noc_pkg::PKT_CLASS_TRACE,
                        src: CORE_ID};
   assign fifo_empty = !fifo_valid;
   assign conf_cts   = (state == ST_CONF);

   // holds exactly one packet, so packing never waits on the link
   flit_fifo #(
      .WIDTH($bits(dbg_noc_pkg::dbg_flit_t)),
      .DEPTH(dbg_noc_pkg::TRACE_PKT_LEN)
   ) u_out_fifo (
      .clk      (clk),
      .rst      (rst),
      .in_data  (pk_flit),
      .in_valid (pk_valid),
      .in_ready (pk_ready),
      .out_data (fifo_flit),
      .out_valid(fifo_valid),
      .out_ready(net_out_ready && !conf_cts)
   );

   // link mux, fifo is empty whenever config holds the grant
   assign net_out_flit  = conf_cts ? conf_out_flit : fifo_flit;
   assign net_out_valid = conf_cts ? conf_out_valid : fifo_valid;

   always_comb begin
      state_next = state;
      pk_flit    = '{ftype: dbg_noc_pkg::FLIT_PAYLOAD, data: 16'h0000};
      pk_valid   = 1'b0;
      rec_ready  = 1'b0;
      case (state)
         ST_IDLE: begin
            // new packet only after the previous one has fully left
            if (conf_rts && fifo_empty) begin
               state_next = ST_CONF;
            end else if (rec_valid && fifo_empty) begin
               rec_ready  = 1'b1; // pop one record
               state_next = ST_HEADER;
            end
         end
         ST_CONF: if (!conf_rts && !conf_out_valid) state_next = ST_IDLE;
         ST_HEADER: begin
            pk_flit  = '{ftype: dbg_noc_pkg::FLIT_HEADER, data: trace_hdr};
            pk_valid = 1'b1;
            if (pk_ready) state_next = ST_TS_MSB;
         end
         ST_TS_MSB: begin
            pk_flit.data = rec_buf.timestamp[31:16];
            pk_valid     = 1'b1;
            if (pk_ready) state_next = ST_TS_LSB;
         end
         ST_TS_LSB: begin
            pk_flit.data = rec_buf.timestamp[15:0];
            pk_valid     = 1'b1;
            if (pk_ready) state_next = ST_PC_MSB;
         end
         ST_PC_MSB: begin
            pk_flit.data = rec_buf.pc[31:16];
            pk_valid     = 1'b1;
            if (pk_ready) state_next = ST_PC_LSB;
         end
         ST_PC_LSB: begin
            pk_flit.data = rec_buf.pc[15:0];
            pk_valid     = 1'b1;
            if (pk_ready) state_next = ST_COUNT;
         end
         ST_COUNT: begin
            pk_flit  = '{ftype: dbg_noc_pkg::FLIT_LAST, data: {8'h00, rec_buf.icount}};
            pk_valid = 1'b1;
            if (pk_ready) state_next = ST_IDLE;
         end
         default: state_next = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rec_valid && rec_ready) rec_buf <= rec;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state           <= ST_IDLE;
         sys_clk_disable <= 1'b0;
      end else begin
         state           <= state_next;
         sys_clk_disable <= trace_full; // stall core while records would be lost
      end
   end

endmodule

//--- src/itm_trace_port.sv
// Instruction trace port top level
module itm_trace_port #(
   parameter logic [7:0] CORE_ID          = 8'h00,
   parameter int         TRACE_FIFO_DEPTH = 4
) (
   input  logic                    clk,
   input  logic                    rst,
   input  dbg_noc_pkg::trace_rec_t trace_in,
   input  logic                    trace_valid,
   output logic                    trace_ready,
   output dbg_noc_pkg::dbg_flit_t  out_flit,
   output logic                    out_valid,
   input  logic                    out_ready,
   input  dbg_noc_pkg::dbg_flit_t  in_flit,
   input  logic                    in_valid,
   output logic                    in_ready,
   output logic                    sys_clk_disable,
   output dbg_noc_pkg::itm_conf_t  conf
);

   dbg_noc_pkg::trace_rec_t rec;       // trace fifo head
   logic                    rec_valid;
   logic                    rec_ready;
   logic                    trace_full;
   dbg_noc_pkg::dbg_flit_t  conf_out_flit;
   logic                    conf_out_valid;
   logic                    conf_rts;
   logic                    conf_cts;

   assign trace_full = !trace_ready;

   flit_fifo #(.WIDTH($bits(dbg_noc_pkg::trace_rec_t)), .DEPTH(TRACE_FIFO_DEPTH)) u_trace_fifo (
      .clk(clk), .rst(rst),
      .in_data(trace_in), .in_valid(trace_valid), .in_ready(trace_ready),
      .out_data(rec), .out_valid(rec_valid), .out_ready(rec_ready)
   );

   itm_dbgnoc_if #(.CORE_ID(CORE_ID)) u_dbgnoc_if (
      .clk(clk), .rst(rst),
      .rec(rec), .rec_valid(rec_valid), .rec_ready(rec_ready), .trace_full(trace_full),
      .net_out_flit(out_flit), .net_out_valid(out_valid), .net_out_ready(out_ready),
      .conf_out_flit(conf_out_flit), .conf_out_valid(conf_out_valid),
      .conf_rts(conf_rts), .conf_cts(conf_cts), .sys_clk_disable(sys_clk_disable)
   );

   // every inbound flit lands here, foreign classes are dropped inside
   dbg_conf_if #(.CORE_ID(CORE_ID)) u_conf_if (
      .clk(clk), .rst(rst),
      .in_flit(in_flit), .in_valid(in_valid), .in_ready(in_ready),
      .out_flit(conf_out_flit), .out_valid(conf_out_valid), .out_ready(out_ready),
      .conf_rts(conf_rts), .conf_cts(conf_cts), .conf(conf)
   );

endmodule

//--- test/itm_cases.txt
# T: timestamp pc icount | B: record count | S: record limit | F: source id
# W: source addr data | R: source addr expected data | all values hex
T 12345678 80001234 05
T deadbeef 0000fffc ff
T 00000000 ffffffff 00
B 8
R 05 0002 0000
R 05 0004 ffff
W 05 0002 1234
W 05 0003 5678
R 05 0002 1234
R 23 0003 5678
W 07 0004 0000
W 07 0005 8000
R 07 0004 0000
R 07 0005 8000
W 05 0000 ffff
W 05 0001 ffff
R 05 0000 0200
R 05 0001 002a
R 05 0006 0000
R 05 00ff 0000
S 0c
F 05
R 05 0002 1234
T 00000001 00000002 03
B 5

//--- test/tb_itm_trace_port.sv
// Trace port testbench
module tb_itm_trace_port;
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [7:0] CORE_ID = 8'h2a;
   localparam int TIMEOUT = 200; // cycles per wait
   localparam int QUIET   = 20;  // idle window after a foreign packet

   logic                    clk = 1'b0;
   logic                    rst;
   dbg_noc_pkg::trace_rec_t trace_in;
   logic                    trace_valid;
   logic                    trace_ready;
   dbg_noc_pkg::dbg_flit_t  out_flit;
   logic                    out_valid;
   logic                    out_ready;
   dbg_noc_pkg::dbg_flit_t  in_flit;
   logic                    in_valid;
   logic                    in_ready;
   logic                    sys_clk_disable;
   dbg_noc_pkg::itm_conf_t  conf;

   dbg_noc_pkg::dbg_flit_t  pkt_q[$];    // last packet off the link
   dbg_noc_pkg::dbg_flit_t  exp_flits[$];
   dbg_noc_pkg::trace_rec_t send_q[$];   // records not yet pushed
   dbg_noc_pkg::trace_rec_t exp_q[$];    // records not yet seen on the link
   dbg_noc_pkg::itm_conf_t  model_conf;  // expected trigger bounds
   int                      fd;
   int                      errors = 0;
   int                      n_pass = 0;
   int                      n_fail = 0;

   always #10 clk = ~clk; // 20 ns period

   itm_trace_port #(.CORE_ID(CORE_ID), .TRACE_FIFO_DEPTH(4)) DUT (
      .clk(clk), .rst(rst),
      .trace_in(trace_in), .trace_valid(trace_valid), .trace_ready(trace_ready),
      .out_flit(out_flit), .out_valid(out_valid), .out_ready(out_ready),
      .in_flit(in_flit), .in_valid(in_valid), .in_ready(in_ready),
      .sys_clk_disable(sys_clk_disable), .conf(conf)
   );

   task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
      if (got !== exp) begin
         $display("Mismatch at time %0t: %s, got %0h expected %0h", $time, msg, got, exp);
         errors++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout at time %0t: %s", $time, what);
      errors++;
   endtask

   function automatic dbg_noc_pkg::dbg_flit_t make_flit(input dbg_noc_pkg::flit_type_e t,
                                                        input logic [15:0] d);
      return '{ftype: t, data: d};
   endfunction

   // dest, class, source id
   function automatic logic [15:0] header_word(input logic [4:0] dest,
                                               input dbg_noc_pkg::pkt_class_e cls,
                                               input logic [7:0] src);
      return {dest, cls, src};
   endfunction

   function automatic dbg_noc_pkg::trace_rec_t random_record();
      dbg_noc_pkg::trace_rec_t r;
      logic [31:0]             tmp;
      r.timestamp = $urandom;
      r.pc        = $urandom;
      tmp         = $urandom;
      r.icount    = tmp[7:0];
      return r;
   endfunction

   // all drivers below start and end on a falling edge
   task automatic push_record(input dbg_noc_pkg::trace_rec_t r);
      int waited;
      waited      = 0;
      trace_in    = r;
      trace_valid = 1'b1;
      #1;
      while (!trace_ready && waited < TIMEOUT) begin
         @(negedge clk);
         #1;
         waited++;
      end
      if (!trace_ready) report_timeout("trace_ready never rose");
      @(negedge clk); // taken on the rising edge just passed
      trace_valid = 1'b0;
   endtask

   task automatic send_flit(input dbg_noc_pkg::dbg_flit_t f);
      int waited;
      waited   = 0;
      in_flit  = f;
      in_valid = 1'b1;
      #1;
      while (!in_ready && waited < TIMEOUT) begin
         @(negedge clk);
         #1;
         waited++;
      end
      if (!in_ready) report_timeout("in_ready never rose");
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   // gathers flits up to and including a last flit
   task automatic collect_packet(input bit stall);
      int waited;
      bit done;
      waited = 0;
      done   = 1'b0;
      pkt_q.delete();
      while (!done) begin
         out_ready = stall ? ($urandom_range(3) != 0) : 1'b1; // about one stall in four
         #1;
         if (out_valid && out_ready) begin
            pkt_q.push_back(out_flit);
            waited = 0;
            done   = (out_flit.ftype == dbg_noc_pkg::FLIT_LAST);
         end else begin
            waited++;
            if (waited > TIMEOUT) begin
               report_timeout("packet never completed on out_flit");
               done = 1'b1;
            end
         end
         @(negedge clk);
      end
   endtask

   task automatic check_packet(input string tag);
      check(pkt_q.size(), exp_flits.size(), {tag, " flit count"});
      foreach (exp_flits[i]) begin
         if (i < pkt_q.size()) check(pkt_q[i], exp_flits[i], $sformatf("%s flit %0d", tag, i));
      end
   endtask

   // header, ts hi, ts lo, pc hi, pc lo, count
   task automatic expect_trace(input dbg_noc_pkg::trace_rec_t r);
      exp_flits.delete();
      exp_flits.push_back(make_flit(dbg_noc_pkg::FLIT_HEADER,
         header_word(dbg_noc_pkg::HOST_ADDR, dbg_noc_pkg::PKT_CLASS_TRACE, CORE_ID)));
      exp_flits.push_back(make_flit(dbg_noc_pkg::FLIT_PAYLOAD, r.timestamp[31:16]));
      exp_flits.push_back(make_flit(dbg_noc_pkg::FLIT_PAYLOAD, r.timestamp[15:0]));
      exp_flits.push_back(make_flit(dbg_noc_pkg::FLIT_PAYLOAD, r.pc[31:16]));
      exp_flits.push_back(make_flit(dbg_noc_pkg::FLIT_PAYLOAD, r.pc[15:0]));
      exp_flits.push_back(make_flit(dbg_noc_pkg::FLIT_LAST, {8'h00, r.icount}));
   endtask

   task automatic trace_single(input dbg_noc_pkg::trace_rec_t r);
      expect_trace(r);
      fork
         push_record(r);
         collect_packet(1'b0);
      join
      check_packet("trace");
   endtask

   task automatic burst_under_stalls(input int n);
      dbg_noc_pkg::trace_rec_t r;
      for (int i = 0; i < n; i++) begin
         r = random_record();
         send_q.push_back(r);
         exp_q.push_back(r);
      end
      fork
         while (send_q.size() > 0) push_record(send_q.pop_front());
         while (exp_q.size() > 0) begin
            collect_packet(1'b1);
            expect_trace(exp_q.pop_front()); // input order
            check_packet("burst");
         end
      join
   endtask

   task automatic stall_and_drain(input int n);
      dbg_noc_pkg::trace_rec_t r;
      bit                      full;
      full      = 1'b0;
      out_ready = 1'b0; // link blocked
      while (!full && exp_q.size() < n) begin
         r           = random_record();
         trace_in    = r;
         trace_valid = 1'b1;
         #1;
         if (trace_ready) exp_q.push_back(r);
         else full = 1'b1;
         @(negedge clk);
      end
      trace_valid = 1'b0;
      check(full, 1'b1, "trace_ready fell with out_ready low");
      #1;
      check(sys_clk_disable, 1'b1, "sys_clk_disable one cycle after full");
      @(negedge clk);
      while (exp_q.size() > 0) begin
         collect_packet(1'b0);
         expect_trace(exp_q.pop_front());
         check_packet("drain");
      end
      check(sys_clk_disable, 1'b0, "sys_clk_disable after drain");
   endtask

   task automatic write_register(input logic [7:0] src, input logic [15:0] addr,
                                 input logic [15:0] data);
      send_flit(make_flit(dbg_noc_pkg::FLIT_HEADER,
         header_word(5'd1, dbg_noc_pkg::PKT_CLASS_CONF_WRITE, src)));
      send_flit(make_flit(dbg_noc_pkg::FLIT_PAYLOAD, addr));
      send_flit(make_flit(dbg_noc_pkg::FLIT_LAST, data));
      case (addr)
         16'd2: model_conf.pc_lower[31:16] = data;
         16'd3: model_conf.pc_lower[15:0]  = data;
         16'd4: model_conf.pc_upper[31:16] = data;
         16'd5: model_conf.pc_upper[15:0]  = data;
         default: ; // id registers and holes keep their value
      endcase
      check(conf, model_conf, $sformatf("conf after write to %0h", addr));
   endtask

   task automatic read_register(input logic [7:0] src, input logic [15:0] addr,
                                input logic [15:0] exp);
      send_flit(make_flit(dbg_noc_pkg::FLIT_HEADER,
         header_word(5'd1, dbg_noc_pkg::PKT_CLASS_CONF_READ, src)));
      send_flit(make_flit(dbg_noc_pkg::FLIT_LAST, addr));
      exp_flits.delete();
      exp_flits.push_back(make_flit(dbg_noc_pkg::FLIT_HEADER,
         header_word(src[4:0], dbg_noc_pkg::PKT_CLASS_CONF_RESP, CORE_ID))); // back to requester
      exp_flits.push_back(make_flit(dbg_noc_pkg::FLIT_PAYLOAD, addr));
      exp_flits.push_back(make_flit(dbg_noc_pkg::FLIT_LAST, exp));
      collect_packet(1'b0);
      check_packet($sformatf("read %0h", addr));
   endtask

   task automatic foreign_packet(input logic [7:0] src);
      int seen;
      seen = 0;
      send_flit(make_flit(dbg_noc_pkg::FLIT_HEADER,
         header_word(5'd1, dbg_noc_pkg::PKT_CLASS_TRACE, src)));
      send_flit(make_flit(dbg_noc_pkg::FLIT_PAYLOAD, 16'h0bad));
      send_flit(make_flit(dbg_noc_pkg::FLIT_LAST, 16'hf00d));
      repeat (QUIET) begin
         out_ready = 1'b1;
         #1;
         if (out_valid) seen++;
         @(negedge clk);
      end
      check(seen, 0, "flits sent after foreign packet");
   endtask

   task automatic report_test(input int num, input string name, input int errs_before);
      if (errors == errs_before) n_pass++;
      else n_fail++;
      $display("test %0d %s: %s", num, name, (errors == errs_before) ? "passed" : "failed");
   endtask

   task automatic dispatch_case(input logic [7:0] op, input int num);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      int          want;
      int          code;
      int          errs_before;
      string       name;
      errs_before = errors;
      want = (op == "T" || op == "W" || op == "R") ? 3 : 1;
      code = (want == 3) ? $fscanf(fd, "%h %h %h", a, b, c) : $fscanf(fd, "%h", a);
      if (code != want) begin
         $display("Malformed operands for opcode %s in cases file", op);
         errors++;
      end
      case (op)
         "T": begin
            name = "trace packet";
            trace_single('{timestamp: a, pc: b, icount: c[7:0]});
         end
         "B": begin
            name = "burst under stalls";
            burst_under_stalls(a);
         end
         "W": begin
            name = "config write";
            write_register(a[7:0], b[15:0], c[15:0]);
         end
         "R": begin
            name = "config read";
            read_register(a[7:0], b[15:0], c[15:0]);
         end
         "S": begin
            name = "stall and drain";
            stall_and_drain(a);
         end
         "F": begin
            name = "foreign packet";
            foreign_packet(a[7:0]);
         end
         default: begin
            name = "unknown";
            $display("Unknown opcode %s in cases file", op);
            errors++;
         end
      endcase
      report_test(num, name, errs_before);
   endtask

   task automatic skip_line();
      int ch;
      ch = $fgetc(fd);
      while (ch != "\n" && ch != -1) ch = $fgetc(fd);
   endtask

   initial begin
      int         num;
      logic [7:0] op;
      void'($urandom(32'hb83adb9a)); // seeded once
      rst         = 1'b1;
      trace_in    = '0;
      trace_valid = 1'b0;
      out_ready   = 1'b1;
      in_flit     = '0;
      in_valid    = 1'b0;
      model_conf  = '{pc_lower: 32'h0000_0000, pc_upper: 32'hffff_ffff};
      repeat (3) @(negedge clk); // three rising edges in reset
      rst = 1'b0;
      #1;
      check(out_valid, 1'b0, "out_valid after reset");
      check(sys_clk_disable, 1'b0, "sys_clk_disable after reset");
      check(trace_ready, 1'b1, "trace_ready after reset");
      check(in_ready, 1'b1, "in_ready after reset");
      check(conf, model_conf, "conf after reset");
      report_test(0, "reset", 0);
      @(negedge clk);
      num = 1;
      fd  = $fopen("test/itm_cases.txt", "r");
      if (fd == 0) begin
         $display("Could not open test/itm_cases.txt");
         errors++;
      end else begin
         while ($fscanf(fd, " %c", op) == 1) begin
            if (op == "#") begin
               skip_line();
            end else begin
               dispatch_case(op, num);
               num++;
            end
         end
         $fclose(fd);
      end
      $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
      if (errors == 0 && n_pass > 1) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule
